// File: hw/wt_cache_config.svh
//////////////////////////////////////////////////
// cache subsystem configuration
// widths and line count shared by the package
// and the cache modules
//////////////////////////////////////////////////

`ifndef WT_CACHE_CONFIG_SVH
`define WT_CACHE_CONFIG_SVH

// byte address width
`define WT_ADDR_W 32

// word width, one word per line
`define WT_DATA_W 32

// line index width, taken from address bits 5..2
`define WT_INDEX_W 4

// number of lines in each cache
`define WT_LINES 16

`endif

// File: hw/wt_cache_pkg.sv
//////////////////////////////////////////////////
// cache subsystem package
// vector types and FSM state encodings
//////////////////////////////////////////////////

`include "wt_cache_config.svh"

package wt_cache_pkg;

  // vectors with a meaning
  typedef logic [`WT_ADDR_W-1:0]              addr_t;
  typedef logic [`WT_DATA_W-1:0]              word_t;
  typedef logic [`WT_DATA_W/8-1:0]            be_t;
  typedef logic [`WT_INDEX_W-1:0]             index_t;
  // tag is everything above index and byte offset
  typedef logic [`WT_ADDR_W-`WT_INDEX_W-3:0]  tag_t;

  // instruction cache FSM
  typedef enum logic [1:0] {
    IC_IDLE,
    IC_LOOKUP,
    IC_REFILL
  } icache_state_e;

  // data cache FSM
  typedef enum logic [2:0] {
    DC_IDLE,
    DC_LOOKUP,
    DC_REFILL,
    DC_WRITE,
    DC_FLUSH
  } dcache_state_e;

  // memory adapter FSM
  typedef enum logic {
    ARB_IDLE,
    ARB_BUSY
  } arb_state_e;

endpackage

// File: hw/wt_cache_subsystem.sv
//////////////////////////////////////////////////
// cache subsystem top level
// instruction and data cache fanning into one
// Wishbone memory adapter
//////////////////////////////////////////////////

module wt_cache_subsystem (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // fetch port
  input  logic                 fetch_req_i,
  input  wt_cache_pkg::addr_t  fetch_addr_i,
  output logic                 fetch_valid_o,
  output wt_cache_pkg::word_t  fetch_data_o,
  // data port
  input  logic                 data_req_i,
  input  logic                 data_we_i,
  input  wt_cache_pkg::addr_t  data_addr_i,
  input  wt_cache_pkg::word_t  data_wdata_i,
  input  wt_cache_pkg::be_t    data_be_i,
  output logic                 data_ack_o,
  output wt_cache_pkg::word_t  data_rdata_o,
  // cache maintenance
  input  logic                 icache_flush_i,
  input  logic                 dcache_flush_i,
  output logic                 dcache_flush_ack_o,
  // Wishbone master
  output logic                 wb_cyc_o,
  output logic                 wb_stb_o,
  output logic                 wb_we_o,
  output wt_cache_pkg::addr_t  wb_adr_o,
  output wt_cache_pkg::word_t  wb_dat_o,
  output wt_cache_pkg::be_t    wb_sel_o,
  input  logic                 wb_ack_i,
  input  wt_cache_pkg::word_t  wb_dat_i,
  // status
  output logic                 icache_miss_o,
  output logic                 dcache_miss_o,
  output logic                 busy_o
);

  import wt_cache_pkg::*;

  // icache to adapter
  logic   ic_mem_req;
  addr_t  ic_mem_addr;
  logic   ic_mem_ack;

  // dcache to adapter
  logic   dc_mem_req;
  logic   dc_mem_we;
  addr_t  dc_mem_addr;
  word_t  dc_mem_wdata;
  be_t    dc_mem_be;
  logic   dc_mem_ack;

  // read data shared by both returns
  word_t  mem_rdata;

  logic   icache_busy;
  logic   dcache_busy;

  assign busy_o = icache_busy | dcache_busy;

  wt_icache u_wt_icache (
    .clk_i         ( clk_i          ),
    .rst_i         ( rst_i          ),
    .flush_i       ( icache_flush_i ),
    .fetch_req_i   ( fetch_req_i    ),
    .fetch_addr_i  ( fetch_addr_i   ),
    .fetch_valid_o ( fetch_valid_o  ),
    .fetch_data_o  ( fetch_data_o   ),
    .miss_o        ( icache_miss_o  ),
    .busy_o        ( icache_busy    ),
    .mem_req_o     ( ic_mem_req     ),
    .mem_addr_o    ( ic_mem_addr    ),
    .mem_ack_i     ( ic_mem_ack     ),
    .mem_rdata_i   ( mem_rdata      )
  );

  wt_dcache u_wt_dcache (
    .clk_i        ( clk_i              ),
    .rst_i        ( rst_i              ),
    .flush_i      ( dcache_flush_i     ),
    .flush_ack_o  ( dcache_flush_ack_o ),
    .data_req_i   ( data_req_i         ),
    .data_we_i    ( data_we_i          ),
    .data_addr_i  ( data_addr_i        ),
    .data_wdata_i ( data_wdata_i       ),
    .data_be_i    ( data_be_i          ),
    .data_ack_o   ( data_ack_o         ),
    .data_rdata_o ( data_rdata_o       ),
    .miss_o       ( dcache_miss_o      ),
    .busy_o       ( dcache_busy        ),
    .mem_req_o    ( dc_mem_req         ),
    .mem_we_o     ( dc_mem_we          ),
    .mem_addr_o   ( dc_mem_addr        ),
    .mem_wdata_o  ( dc_mem_wdata       ),
    .mem_be_o     ( dc_mem_be          ),
    .mem_ack_i    ( dc_mem_ack         ),
    .mem_rdata_i  ( mem_rdata          )
  );

  wt_mem_arbiter u_wt_mem_arbiter (
    .clk_i      ( clk_i        ),
    .rst_i      ( rst_i        ),
    .ic_req_i   ( ic_mem_req   ),
    .ic_addr_i  ( ic_mem_addr  ),
    .ic_ack_o   ( ic_mem_ack   ),
    .dc_req_i   ( dc_mem_req   ),
    .dc_we_i    ( dc_mem_we    ),
    .dc_addr_i  ( dc_mem_addr  ),
    .dc_wdata_i ( dc_mem_wdata ),
    .dc_be_i    ( dc_mem_be    ),
    .dc_ack_o   ( dc_mem_ack   ),
    .rdata_o    ( mem_rdata    ),
    .wb_cyc_o   ( wb_cyc_o     ),
    .wb_stb_o   ( wb_stb_o     ),
    .wb_we_o    ( wb_we_o      ),
    .wb_adr_o   ( wb_adr_o     ),
    .wb_dat_o   ( wb_dat_o     ),
    .wb_sel_o   ( wb_sel_o     ),
    .wb_ack_i   ( wb_ack_i     ),
    .wb_dat_i   ( wb_dat_i     )
  );

endmodule

// File: hw/wt_dcache.sv
//////////////////////////////////////////////////
// data cache
// direct-mapped, write-through, no write allocate
// read misses refill one word, flush handshake
//////////////////////////////////////////////////

`include "wt_cache_config.svh"

module wt_dcache (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 flush_i,
  output logic                 flush_ack_o,
  input  logic                 data_req_i,
  input  logic                 data_we_i,
  input  wt_cache_pkg::addr_t  data_addr_i,
  input  wt_cache_pkg::word_t  data_wdata_i,
  input  wt_cache_pkg::be_t    data_be_i,
  output logic                 data_ack_o,
  output wt_cache_pkg::word_t  data_rdata_o,
  output logic                 miss_o,
  output logic                 busy_o,
  output logic                 mem_req_o,
  output logic                 mem_we_o,
  output wt_cache_pkg::addr_t  mem_addr_o,
  output wt_cache_pkg::word_t  mem_wdata_o,
  output wt_cache_pkg::be_t    mem_be_o,
  input  logic                 mem_ack_i,
  input  wt_cache_pkg::word_t  mem_rdata_i
);

  import wt_cache_pkg::*;

  dcache_state_e         state_q;
  // request fields, captured while idle
  addr_t                 addr_q;
  word_t                 wdata_q;
  be_t                   be_q;

  // line storage
  tag_t                  tag_arr_q  [`WT_LINES];
  word_t                 data_arr_q [`WT_LINES];
  logic [`WT_LINES-1:0]  valid_q;

  index_t                idx;
  tag_t                  tag;
  logic                  hit;

  // byte-wise merge of store data into a line
  function automatic word_t merge_bytes(word_t old_w, word_t new_w, be_t be);
    word_t res;
    res = old_w;
    for (int b = 0; b < `WT_DATA_W/8; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  //////////////////////////////////////////////////
  // lookup and memory port
  //////////////////////////////////////////////////

  assign idx = addr_q[`WT_INDEX_W+1:2];
  assign tag = addr_q[`WT_ADDR_W-1:`WT_INDEX_W+2];
  assign hit = valid_q[idx] && (tag_arr_q[idx] == tag);

  // read misses only, writes never look up
  assign miss_o      = (state_q == DC_LOOKUP) && !hit;
  assign busy_o      = (state_q != DC_IDLE);
  // flush state lasts exactly one cycle
  assign flush_ack_o = (state_q == DC_FLUSH);

  assign mem_req_o   = (state_q == DC_REFILL) || (state_q == DC_WRITE);
  assign mem_we_o    = (state_q == DC_WRITE);
  assign mem_addr_o  = {addr_q[`WT_ADDR_W-1:2], 2'b00};
  assign mem_wdata_o = wdata_q;
  // refill reads the whole word
  assign mem_be_o    = (state_q == DC_WRITE) ? be_q : '1;

  //////////////////////////////////////////////////
  // control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= DC_IDLE;
      valid_q    <= '0;
      data_ack_o <= 1'b0;
    end else begin
      data_ack_o <= 1'b0;
      case (state_q)
        DC_IDLE: begin
          // flush has priority over a new access
          if (flush_i) begin
            valid_q <= '0;
            state_q <= DC_FLUSH;
          end else if (data_req_i && !data_ack_o) begin
            state_q <= data_we_i ? DC_WRITE : DC_LOOKUP;
          end
        end
        DC_LOOKUP: begin
          if (hit) begin
            data_ack_o <= 1'b1;
            state_q    <= DC_IDLE;
          end else begin
            state_q <= DC_REFILL;
          end
        end
        DC_REFILL: begin
          if (mem_ack_i) begin
            valid_q[idx] <= 1'b1;
            data_ack_o   <= 1'b1;
            state_q      <= DC_IDLE;
          end
        end
        DC_WRITE: begin
          // store completes once memory has taken it
          if (mem_ack_i) begin
            data_ack_o <= 1'b1;
            state_q    <= DC_IDLE;
          end
        end
        DC_FLUSH: state_q <= DC_IDLE;
        default:  state_q <= DC_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // request fields, arrays and read data
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (state_q == DC_IDLE) begin
      addr_q  <= data_addr_i;
      wdata_q <= data_wdata_i;
      be_q    <= data_be_i;
    end
    if (state_q == DC_LOOKUP) begin
      data_rdata_o <= data_arr_q[idx];
    end
    if ((state_q == DC_REFILL) && mem_ack_i) begin
      tag_arr_q[idx]  <= tag;
      data_arr_q[idx] <= mem_rdata_i;
      data_rdata_o    <= mem_rdata_i;
    end
    // write hit keeps the cached copy in step with memory
    if ((state_q == DC_WRITE) && mem_ack_i && hit) begin
      data_arr_q[idx] <= merge_bytes(data_arr_q[idx], wdata_q, be_q);
    end
  end

endmodule

// File: hw/wt_icache.sv
//////////////////////////////////////////////////
// instruction cache
// direct-mapped, read-only, one word per line
// registered lookup, refill through the adapter
//////////////////////////////////////////////////

`include "wt_cache_config.svh"

module wt_icache (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 flush_i,
  input  logic                 fetch_req_i,
  input  wt_cache_pkg::addr_t  fetch_addr_i,
  output logic                 fetch_valid_o,
  output wt_cache_pkg::word_t  fetch_data_o,
  output logic                 miss_o,
  output logic                 busy_o,
  output logic                 mem_req_o,
  output wt_cache_pkg::addr_t  mem_addr_o,
  input  logic                 mem_ack_i,
  input  wt_cache_pkg::word_t  mem_rdata_i
);

  import wt_cache_pkg::*;

  icache_state_e         state_q;
  // request address, captured while idle
  addr_t                 addr_q;

  // line storage
  tag_t                  tag_arr_q  [`WT_LINES];
  word_t                 data_arr_q [`WT_LINES];
  logic [`WT_LINES-1:0]  valid_q;

  index_t                idx;
  tag_t                  tag;
  logic                  hit;

  //////////////////////////////////////////////////
  // lookup
  //////////////////////////////////////////////////

  assign idx = addr_q[`WT_INDEX_W+1:2];
  assign tag = addr_q[`WT_ADDR_W-1:`WT_INDEX_W+2];
  assign hit = valid_q[idx] && (tag_arr_q[idx] == tag);

  // one-cycle pulse, lookup lasts one cycle
  assign miss_o = (state_q == IC_LOOKUP) && !hit;
  assign busy_o = (state_q != IC_IDLE);

  // word-aligned read towards the adapter
  assign mem_req_o  = (state_q == IC_REFILL);
  assign mem_addr_o = {addr_q[`WT_ADDR_W-1:2], 2'b00};

  //////////////////////////////////////////////////
  // control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q       <= IC_IDLE;
      valid_q       <= '0;
      fetch_valid_o <= 1'b0;
    end else begin
      fetch_valid_o <= 1'b0;
      case (state_q)
        IC_IDLE: begin
          // flush wins, a held fetch is taken next cycle
          if (flush_i) begin
            valid_q <= '0;
          end else if (fetch_req_i && !fetch_valid_o) begin
            // skip the ack cycle, req still high from last fetch
            state_q <= IC_LOOKUP;
          end
        end
        IC_LOOKUP: begin
          if (hit) begin
            fetch_valid_o <= 1'b1;
            state_q       <= IC_IDLE;
          end else begin
            state_q <= IC_REFILL;
          end
        end
        IC_REFILL: begin
          // wait for the adapter, then fill and return
          if (mem_ack_i) begin
            valid_q[idx]  <= 1'b1;
            fetch_valid_o <= 1'b1;
            state_q       <= IC_IDLE;
          end
        end
        default: state_q <= IC_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // address, arrays and read data
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (state_q == IC_IDLE) begin
      addr_q <= fetch_addr_i;
    end
    if (state_q == IC_LOOKUP) begin
      fetch_data_o <= data_arr_q[idx];
    end
    // refill writes the line and forwards the word
    if ((state_q == IC_REFILL) && mem_ack_i) begin
      tag_arr_q[idx]  <= tag;
      data_arr_q[idx] <= mem_rdata_i;
      fetch_data_o    <= mem_rdata_i;
    end
  end

endmodule

// File: hw/wt_mem_arbiter.sv
//////////////////////////////////////////////////
// memory adapter
// round-robin between both caches onto one
// Wishbone classic master port
//////////////////////////////////////////////////

module wt_mem_arbiter (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 ic_req_i,
  input  wt_cache_pkg::addr_t  ic_addr_i,
  output logic                 ic_ack_o,
  input  logic                 dc_req_i,
  input  logic                 dc_we_i,
  input  wt_cache_pkg::addr_t  dc_addr_i,
  input  wt_cache_pkg::word_t  dc_wdata_i,
  input  wt_cache_pkg::be_t    dc_be_i,
  output logic                 dc_ack_o,
  output wt_cache_pkg::word_t  rdata_o,
  output logic                 wb_cyc_o,
  output logic                 wb_stb_o,
  output logic                 wb_we_o,
  output wt_cache_pkg::addr_t  wb_adr_o,
  output wt_cache_pkg::word_t  wb_dat_o,
  output wt_cache_pkg::be_t    wb_sel_o,
  input  logic                 wb_ack_i,
  input  wt_cache_pkg::word_t  wb_dat_i
);

  import wt_cache_pkg::*;

  arb_state_e  state_q;
  logic        cyc_q;
  // last grant, 1 for dcache, also the current owner while busy
  logic        last_dc_q;
  logic        ic_go;
  logic        dc_go;
  logic        pick_dc;

  // a cache still sees its ack this cycle, its req is stale
  assign ic_go   = ic_req_i && !ic_ack_o;
  assign dc_go   = dc_req_i && !dc_ack_o;
  // on a tie the cache not served last wins
  assign pick_dc = dc_go && (!ic_go || !last_dc_q);

  // classic single transfer, stb follows cyc
  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;

  //////////////////////////////////////////////////
  // grant FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= ARB_IDLE;
      cyc_q     <= 1'b0;
      last_dc_q <= 1'b0;
      ic_ack_o  <= 1'b0;
      dc_ack_o  <= 1'b0;
    end else begin
      ic_ack_o <= 1'b0;
      dc_ack_o <= 1'b0;
      case (state_q)
        ARB_IDLE: begin
          if (ic_go || dc_go) begin
            cyc_q     <= 1'b1;
            last_dc_q <= pick_dc;
            state_q   <= ARB_BUSY;
          end
        end
        ARB_BUSY: begin
          // hold the bus through any wait states
          if (wb_ack_i) begin
            cyc_q    <= 1'b0;
            ic_ack_o <= !last_dc_q;
            dc_ack_o <= last_dc_q;
            state_q  <= ARB_IDLE;
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // bus fields and read data
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    // fields only matter once cyc is up
    if (state_q == ARB_IDLE) begin
      wb_we_o  <= pick_dc && dc_we_i;
      wb_adr_o <= pick_dc ? dc_addr_i : ic_addr_i;
      wb_dat_o <= dc_wdata_i;
      // instruction fetches read the full word
      wb_sel_o <= pick_dc ? dc_be_i : '1;
    end
    if ((state_q == ARB_BUSY) && wb_ack_i) begin
      rdata_o <= wb_dat_i;
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the cache subsystem testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_wt_cache_subsystem \
  -f wt_cache_subsystem.f \
  --Mdir obj_dir -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
  echo "simulation reported errors, see sim.log"
  exit 1
fi
echo "simulation finished without errors"

// File: testbench/tb_wb_memory.sv
//////////////////////////////////////////////////
// Wishbone classic slave memory for the testbench
// 256 words, 0 to 3 pseudo-random wait states
//////////////////////////////////////////////////

module tb_wb_memory (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         wb_cyc_i,
  input  logic         wb_stb_i,
  input  logic         wb_we_i,
  input  logic [31:0]  wb_adr_i,
  input  logic [31:0]  wb_dat_i,
  input  logic [3:0]   wb_sel_i,
  output logic         wb_ack_o,
  output logic [31:0]  wb_dat_o
);

  logic [31:0]  mem_q [256];
  logic [31:0]  rng_q;
  logic [31:0]  rng_next;
  logic [1:0]   wait_q;
  logic [7:0]   widx;

  // 32-bit xorshift, shifts 13, 17, 5
  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] r;
    r = x ^ (x << 13);
    r = r ^ (r >> 17);
    r = r ^ (r << 5);
    return r;
  endfunction

  assign widx     = wb_adr_i[9:2];
  assign rng_next = xorshift32(rng_q);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wb_ack_o <= 1'b0;
      rng_q    <= 32'd96540;
      wait_q   <= 2'd0;
      // word n holds n * 0x01010101 xor 0xA5A50000
      for (int n = 0; n < 256; n++) begin
        mem_q[n] <= (32'(n) * 32'h01010101) ^ 32'hA5A50000;
      end
    end else begin
      wb_ack_o <= 1'b0;
      if (wb_cyc_i && wb_stb_i && !wb_ack_o) begin
        if (wait_q == 2'd0) begin
          wb_ack_o <= 1'b1;
          wb_dat_o <= mem_q[widx];
          if (wb_we_i) begin
            for (int b = 0; b < 4; b++) begin
              if (wb_sel_i[b]) begin
                mem_q[widx][8*b +: 8] <= wb_dat_i[8*b +: 8];
              end
            end
          end
          // draw wait states for the next transfer
          rng_q  <= rng_next;
          wait_q <= rng_next[1:0];
        end else begin
          wait_q <= wait_q - 2'd1;
        end
      end
    end
  end

endmodule

// File: testbench/tb_wt_cache_subsystem.sv
//////////////////////////////////////////////////
// testbench for the cache subsystem
// table of accesses, shadow memory, checks
//////////////////////////////////////////////////

module tb_wt_cache_subsystem;

  import wt_cache_pkg::*;

  typedef enum logic [2:0] {FETCH, DATA_RD, DATA_WR, FLUSH_I, FLUSH_D, DUAL} kind_e;

  typedef struct packed {
    kind_e  kind;
    addr_t  addr;
    word_t  wdata;
    be_t    be;
    logic   hit;
  } step_t;

  // data side of a dual access sits this far above the fetch
  localparam addr_t DUAL_DC_OFFSET = 32'h100;

  logic   clk_i, rst_i;
  logic   fetch_req_i, fetch_valid_o;
  addr_t  fetch_addr_i;
  word_t  fetch_data_o;
  logic   data_req_i, data_we_i, data_ack_o;
  addr_t  data_addr_i;
  word_t  data_wdata_i, data_rdata_o;
  be_t    data_be_i;
  logic   icache_flush_i, dcache_flush_i, dcache_flush_ack_o;
  logic   wb_cyc_o, wb_stb_o, wb_we_o, wb_ack_i;
  addr_t  wb_adr_o;
  word_t  wb_dat_o, wb_dat_i;
  be_t    wb_sel_o;
  logic   icache_miss_o, dcache_miss_o, busy_o;

  step_t  steps [$];
  word_t  shadow [256];
  // word each icache line was last filled with
  word_t  ic_seen [256];
  int     data_errs, lat_errs, status_errs;
  int     cycle_cnt, cycle_limit;

  wt_cache_subsystem u_wt_cache_subsystem (.*);

  tb_wb_memory u_tb_wb_memory (
    .clk_i    ( clk_i    ),
    .rst_i    ( rst_i    ),
    .wb_cyc_i ( wb_cyc_o ),
    .wb_stb_i ( wb_stb_o ),
    .wb_we_i  ( wb_we_o  ),
    .wb_adr_i ( wb_adr_o ),
    .wb_dat_i ( wb_dat_o ),
    .wb_sel_i ( wb_sel_o ),
    .wb_ack_o ( wb_ack_i ),
    .wb_dat_o ( wb_dat_i )
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // watchdog with its limit set once the table is built
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if ((cycle_limit > 0) && (cycle_cnt > cycle_limit)) begin
      $display("Timeout: no response within %0d cycles, run stopped", cycle_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic word_t init_word(int n);
    return (word_t'(n) * 32'h01010101) ^ 32'hA5A50000;
  endfunction

  task automatic apply_write(addr_t a, word_t d, be_t be);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        shadow[a[9:2]][8*b +: 8] = d[8*b +: 8];
      end
    end
  endtask

  task automatic add_step(kind_e k, addr_t a, word_t d, be_t be, logic hit);
    step_t s;
    s.kind  = k;
    s.addr  = a;
    s.wdata = d;
    s.be    = be;
    s.hit   = hit;
    steps.push_back(s);
  endtask

  task automatic check_word(string what, addr_t a, word_t got, word_t exp);
    assert (got === exp) else begin
      data_errs++;
      $display("Fail at %0t: %s 0x%08h returned 0x%08h, expected 0x%08h",
               $time, what, a, got, exp);
    end
  endtask

  // a hit answers after 2 cycles with no miss pulse and a miss pulses once
  task automatic check_timing(string what, addr_t a, logic hit, int lat, int misses);
    assert (misses == (hit ? 0 : 1)) else begin
      status_errs++;
      $display("Fail at %0t: %s 0x%08h gave %0d miss pulses", $time, what, a, misses);
    end
    if (hit) begin
      assert (lat == 2) else begin
        lat_errs++;
        $display("Fail at %0t: %s 0x%08h hit took %0d cycles", $time, what, a, lat);
      end
    end else begin
      assert (lat > 2) else begin
        lat_errs++;
        $display("Fail at %0t: %s 0x%08h miss took %0d cycles", $time, what, a, lat);
      end
    end
  endtask

  task automatic flush_dcache();
    int waited;
    waited = 0;
    dcache_flush_i = 1'b1;
    @(negedge clk_i);
    while (!dcache_flush_ack_o) begin
      waited++;
      @(negedge clk_i);
    end
    assert (waited == 1) else begin
      lat_errs++;
      $display("Fail at %0t: flush ack after %0d cycles, expected 1", $time, waited);
    end
    @(posedge clk_i);
    #5;
    dcache_flush_i = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // one fetch, data access or both together
  //////////////////////////////////////////////////

  task automatic run_access(step_t s);
    int     waited, ic_lat, dc_lat, ic_miss_n, dc_miss_n;
    logic   use_ic, use_dc, ic_done, dc_done;
    word_t  ic_got, dc_got, ic_exp;
    addr_t  dc_addr;
    waited    = 0;
    ic_lat    = 0;
    dc_lat    = 0;
    ic_miss_n = 0;
    dc_miss_n = 0;
    use_ic    = (s.kind == FETCH) || (s.kind == DUAL);
    use_dc    = (s.kind == DATA_RD) || (s.kind == DATA_WR) || (s.kind == DUAL);
    dc_addr   = (s.kind == DUAL) ? s.addr + DUAL_DC_OFFSET : s.addr;
    ic_done   = !use_ic;
    dc_done   = !use_dc;
    fetch_req_i  = use_ic;
    fetch_addr_i = s.addr;
    data_req_i   = use_dc;
    data_we_i    = (s.kind == DATA_WR);
    data_addr_i  = dc_addr;
    data_wdata_i = s.wdata;
    data_be_i    = (s.kind == DATA_WR) ? s.be : 4'hF;
    while (!(ic_done && dc_done)) begin
      // sample mid-cycle where outputs have settled
      @(negedge clk_i);
      if (icache_miss_o) ic_miss_n++;
      if (dcache_miss_o) dc_miss_n++;
      if (!ic_done && fetch_valid_o) begin
        ic_done = 1'b1;
        ic_lat  = waited;
        ic_got  = fetch_data_o;
      end
      if (!dc_done && data_ack_o) begin
        dc_done = 1'b1;
        dc_lat  = waited;
        dc_got  = data_rdata_o;
      end
      if (!(ic_done && dc_done) && (waited > 0)) begin
        assert (busy_o) else begin
          status_errs++;
          $display("Fail at %0t: busy_o low while a cache is waiting", $time);
        end
      end
      waited++;
      @(posedge clk_i);
      #5;
      // release each port once answered
      if (ic_done) fetch_req_i = 1'b0;
      if (dc_done) data_req_i = 1'b0;
    end
    if (use_ic) begin
      ic_exp = s.hit ? ic_seen[s.addr[9:2]] : shadow[s.addr[9:2]];
      check_word("fetch", s.addr, ic_got, ic_exp);
      check_timing("fetch", s.addr, s.hit, ic_lat, ic_miss_n);
      ic_seen[s.addr[9:2]] = ic_exp;
    end
    if (use_dc && (s.kind != DATA_WR)) begin
      check_word("data read", dc_addr, dc_got, shadow[dc_addr[9:2]]);
      check_timing("data read", dc_addr, s.hit, dc_lat, dc_miss_n);
    end
    if (s.kind == DATA_WR) begin
      apply_write(s.addr, s.wdata, s.be);
      check_word("memory after write", s.addr, u_tb_wb_memory.mem_q[s.addr[9:2]],
                 shadow[s.addr[9:2]]);
      assert (dc_miss_n == 0) else begin
        status_errs++;
        $display("Fail at %0t: write 0x%08h pulsed dcache miss", $time, s.addr);
      end
    end
  endtask

  task automatic run_step(step_t s);
    @(posedge clk_i);
    #5;
    case (s.kind)
      FLUSH_I: begin
        icache_flush_i = 1'b1;
        @(posedge clk_i);
        #5;
        icache_flush_i = 1'b0;
      end
      FLUSH_D: flush_dcache();
      default: run_access(s);
    endcase
  endtask

  //////////////////////////////////////////////////
  // access table
  //////////////////////////////////////////////////

  task automatic build_table();
    // kind, address, write data, byte enables, expect hit
    add_step(FETCH,   32'h100, 32'h0,        4'h0, 1'b0);
    add_step(FETCH,   32'h100, 32'h0,        4'h0, 1'b1);
    add_step(FETCH,   32'h104, 32'h0,        4'h0, 1'b0);
    add_step(DATA_RD, 32'h020, 32'h0,        4'h0, 1'b0);
    add_step(DATA_RD, 32'h020, 32'h0,        4'h0, 1'b1);
    // partial writes to a cached line then an uncached one
    add_step(DATA_WR, 32'h020, 32'hDEADBEEF, 4'h5, 1'b1);
    add_step(DATA_RD, 32'h020, 32'h0,        4'h0, 1'b1);
    add_step(DATA_WR, 32'h024, 32'h12345678, 4'hC, 1'b0);
    add_step(DATA_RD, 32'h024, 32'h0,        4'h0, 1'b0);
    // 0x020 and 0x060 share index 8
    add_step(DATA_RD, 32'h060, 32'h0,        4'h0, 1'b0);
    add_step(DATA_RD, 32'h020, 32'h0,        4'h0, 1'b0);
    add_step(DATA_RD, 32'h060, 32'h0,        4'h0, 1'b0);
    // store into code leaves the stale word in the icache until flushed
    add_step(DATA_WR, 32'h100, 32'hCAFEF00D, 4'hF, 1'b0);
    add_step(FETCH,   32'h100, 32'h0,        4'h0, 1'b1);
    add_step(FLUSH_I, 32'h0,   32'h0,        4'h0, 1'b0);
    add_step(FETCH,   32'h100, 32'h0,        4'h0, 1'b0);
    add_step(DATA_RD, 32'h024, 32'h0,        4'h0, 1'b1);
    add_step(FLUSH_D, 32'h0,   32'h0,        4'h0, 1'b0);
    add_step(DATA_RD, 32'h024, 32'h0,        4'h0, 1'b0);
    // fetch and data read in the same cycle
    add_step(DUAL,    32'h200, 32'h0,        4'h0, 1'b0);
    add_step(DUAL,    32'h200, 32'h0,        4'h0, 1'b1);
    add_step(DATA_WR, 32'h300, 32'h0BADCAFE, 4'h3, 1'b1);
    add_step(DUAL,    32'h200, 32'h0,        4'h0, 1'b1);
    add_step(DUAL,    32'h208, 32'h0,        4'h0, 1'b0);
    add_step(DUAL,    32'h20C, 32'h0,        4'h0, 1'b0);
    // line of 0x104 was dropped by the icache flush
    add_step(FETCH,   32'h104, 32'h0,        4'h0, 1'b0);
  endtask

  initial begin
    rst_i          = 1'b1;
    fetch_req_i    = 1'b0;
    fetch_addr_i   = '0;
    data_req_i     = 1'b0;
    data_we_i      = 1'b0;
    data_addr_i    = '0;
    data_wdata_i   = '0;
    data_be_i      = '0;
    icache_flush_i = 1'b0;
    dcache_flush_i = 1'b0;
    for (int n = 0; n < 256; n++) begin
      shadow[n]  = init_word(n);
      ic_seen[n] = '0;
    end
    build_table();
    cycle_limit = steps.size() * 20;
    repeat (3) @(posedge clk_i);
    #5;
    rst_i = 1'b0;
    @(negedge clk_i);
    assert (!fetch_valid_o && !data_ack_o && !dcache_flush_ack_o && !wb_cyc_o &&
            !wb_stb_o && !icache_miss_o && !dcache_miss_o && !busy_o) else begin
      status_errs++;
      $display("Fail at %0t: outputs not idle after reset", $time);
    end
    foreach (steps[i]) begin
      run_step(steps[i]);
    end
    $display("errors: data %0d, latency %0d, status %0d", data_errs, lat_errs, status_errs);
    if ((data_errs + lat_errs + status_errs) == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: wt_cache_subsystem.f
+incdir+hw
hw/wt_cache_pkg.sv
hw/wt_icache.sv
hw/wt_dcache.sv
hw/wt_mem_arbiter.sv
hw/wt_cache_subsystem.sv
testbench/tb_wb_memory.sv
testbench/tb_wt_cache_subsystem.sv
